/* hdl/lab4_bus_pkg.sv */
package lab4_bus_pkg;

	////////////////////////////////////////
	// bus transfer types
	////////////////////////////////////////

	// one request is any cycle with cyc and stb high
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [6:0]  adr;
		logic [31:0] dat;
	} bus_req_t;

	// ack lands one cycle after the request
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} bus_rsp_t;

	////////////////////////////////////////
	// register map, byte addresses
	////////////////////////////////////////

	localparam logic [6:0] ADR_CONTROL        = 7'h00;
	localparam logic [6:0] ADR_SHIFT_PRESCALE = 7'h04;
	localparam logic [6:0] ADR_RAMP_DELAY     = 7'h0C;
	localparam logic [6:0] ADR_WILK_STOP      = 7'h10;
	localparam logic [6:0] ADR_USER_WRITE     = 7'h18;

	// control word fields
	localparam int CTL_RUNMODE_BIT    = 1;
	// write starts a ramp, reads back as ramp pending
	localparam int CTL_RAMP_BIT       = 6;
	localparam int CTL_WILK_RESET_BIT = 8;
	localparam int CTL_REGCLR_LSB     = 16;

	// user write: go on write, serial busy on read
	localparam int UW_GO_BIT = 31;

endpackage

/* hdl/lab4_chip_pkg.sv */
package lab4_chip_pkg;

	////////////////////////////////////////
	// chip array constants
	////////////////////////////////////////

	localparam int NUM_LABS = 4;
	// one spare bit so that all-ones can mean every chip
	localparam int LAB_SEL_W = 3;
	localparam logic [LAB_SEL_W-1:0] LAB_SEL_ALL = '1;
	localparam int SERIAL_W = 24;

	typedef logic [SERIAL_W-1:0]  lab_word_t;
	typedef logic [LAB_SEL_W-1:0] lab_sel_t;
	typedef logic [NUM_LABS-1:0]  lab_vec_t;
	typedef logic [7:0]           prescale_t;
	typedef logic [15:0]          wilk_time_t;

	localparam wilk_time_t WILK_STOP_DEFAULT      = 16'd1024;
	localparam prescale_t  SHIFT_PRESCALE_DEFAULT = 8'd0;

	////////////////////////////////////////
	// engine request bundles
	////////////////////////////////////////

	typedef struct packed {
		logic      go;
		lab_sel_t  sel;
		lab_word_t data;
	} serial_req_t;

	typedef struct packed {
		wilk_time_t delay;
		wilk_time_t stop;
	} ramp_cfg_t;

endpackage

/* hdl/lab4_reg_bank.sv */
module lab4_reg_bank (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  lab4_bus_pkg::bus_req_t     bus_req_i,
	output lab4_bus_pkg::bus_rsp_t     bus_rsp_o,
	output lab4_chip_pkg::serial_req_t serial_req_o,
	input  logic                       serial_busy_i,
	output logic                       ramp_start_o,
	output logic                       wilk_reset_o,
	output lab4_chip_pkg::ramp_cfg_t   ramp_cfg_o,
	input  logic                       ramp_pending_i,
	output lab4_chip_pkg::prescale_t   prescale_o,
	output logic                       runmode_o,
	output logic                       regclr_o
);
	import lab4_bus_pkg::*;
	import lab4_chip_pkg::*;

	logic        req;
	logic        wr;
	logic        runmode_q;
	logic        regclr_q;
	prescale_t   prescale_q;
	wilk_time_t  delay_q;
	wilk_time_t  stop_q;
	lab_word_t   uw_data_q;
	lab_sel_t    uw_sel_q;
	logic        go_q;
	logic        ramp_start_q;
	logic        wilk_reset_q;
	logic        ack_q;
	logic [31:0] rdata_d;
	logic [31:0] rdata_q;

	assign req = bus_req_i.cyc && bus_req_i.stb;
	assign wr  = req && bus_req_i.we;

	////////////////////////////////////////
	// readback mux
	////////////////////////////////////////

	always_comb begin
		rdata_d = '0;
		case (bus_req_i.adr)
			ADR_CONTROL: begin
				rdata_d[CTL_RUNMODE_BIT] = runmode_q;
				rdata_d[CTL_RAMP_BIT]    = ramp_pending_i;
				rdata_d[CTL_REGCLR_LSB]  = regclr_q;
			end
			ADR_SHIFT_PRESCALE: rdata_d = 32'(prescale_q);
			ADR_RAMP_DELAY:     rdata_d = 32'(delay_q);
			ADR_WILK_STOP:      rdata_d = 32'(stop_q);
			ADR_USER_WRITE: begin
				rdata_d[SERIAL_W-1:0]          = uw_data_q;
				rdata_d[SERIAL_W +: LAB_SEL_W] = uw_sel_q;
				rdata_d[UW_GO_BIT]             = serial_busy_i;
			end
			// unmapped reads as zero
			default: rdata_d = '0;
		endcase
	end

	////////////////////////////////////////
	// setting registers
	////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			runmode_q  <= 1'b0;
			regclr_q   <= 1'b0;
			prescale_q <= SHIFT_PRESCALE_DEFAULT;
			delay_q    <= '0;
			stop_q     <= WILK_STOP_DEFAULT;
			uw_data_q  <= '0;
			uw_sel_q   <= '0;
		end else if (wr) begin
			case (bus_req_i.adr)
				ADR_CONTROL: begin
					runmode_q <= bus_req_i.dat[CTL_RUNMODE_BIT];
					regclr_q  <= bus_req_i.dat[CTL_REGCLR_LSB];
				end
				ADR_SHIFT_PRESCALE: prescale_q <= prescale_t'(bus_req_i.dat);
				ADR_RAMP_DELAY:     delay_q <= wilk_time_t'(bus_req_i.dat);
				ADR_WILK_STOP:      stop_q <= wilk_time_t'(bus_req_i.dat);
				ADR_USER_WRITE: begin
					uw_data_q <= bus_req_i.dat[SERIAL_W-1:0];
					uw_sel_q  <= bus_req_i.dat[SERIAL_W +: LAB_SEL_W];
				end
				default: ;
			endcase
		end
	end

	// single-cycle strobes, ack and read data all one cycle after the request
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			go_q         <= 1'b0;
			ramp_start_q <= 1'b0;
			wilk_reset_q <= 1'b0;
			ack_q        <= 1'b0;
			rdata_q      <= '0;
		end else begin
			go_q <= wr && (bus_req_i.adr == ADR_USER_WRITE) && bus_req_i.dat[UW_GO_BIT];
			ramp_start_q <= wr && (bus_req_i.adr == ADR_CONTROL)
				&& bus_req_i.dat[CTL_RAMP_BIT];
			wilk_reset_q <= wr && (bus_req_i.adr == ADR_CONTROL)
				&& bus_req_i.dat[CTL_WILK_RESET_BIT];
			ack_q <= req;
			if (req) begin
				rdata_q <= rdata_d;
			end
		end
	end

	assign bus_rsp_o.ack = ack_q;
	assign bus_rsp_o.dat = rdata_q;

	// the shifter itself drops go while busy
	assign serial_req_o.go   = go_q;
	assign serial_req_o.sel  = uw_sel_q;
	assign serial_req_o.data = uw_data_q;

	assign ramp_start_o     = ramp_start_q;
	assign wilk_reset_o     = wilk_reset_q;
	assign ramp_cfg_o.delay = delay_q;
	assign ramp_cfg_o.stop  = stop_q;
	assign prescale_o       = prescale_q;
	assign runmode_o        = runmode_q;
	assign regclr_o         = regclr_q;

endmodule

/* hdl/lab4_serial_shifter.sv */
module lab4_serial_shifter (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  lab4_chip_pkg::serial_req_t serial_req_i,
	input  lab4_chip_pkg::prescale_t   prescale_i,
	output logic                       busy_o,
	output lab4_chip_pkg::lab_vec_t    sin_o,
	output logic                       sclk_o,
	output lab4_chip_pkg::lab_vec_t    pclk_o
);
	import lab4_chip_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOW,
		S_HIGH,
		S_LATCH
	} state_t;

	state_t                        state_q;
	prescale_t                     cnt_q;
	logic [$clog2(SERIAL_W)-1:0]   bit_q;
	lab_word_t                     word_q;
	lab_vec_t                      mask_q;
	prescale_t                     presc_q;
	lab_vec_t                      sel_mask;
	logic                          accept;
	logic                          tick;
	logic                          last_bit;

	// all-ones select hits every chip, out-of-range selects hit none
	assign sel_mask = (serial_req_i.sel == LAB_SEL_ALL) ? '1 :
		(lab_vec_t'(1) << serial_req_i.sel);

	assign accept   = (state_q == S_IDLE) && serial_req_i.go;
	assign tick     = (cnt_q == '0);
	assign last_bit = (bit_q == ($clog2(SERIAL_W))'(SERIAL_W - 1));

	////////////////////////////////////////
	// bit sequencer
	////////////////////////////////////////

	// every phase lasts P+1 cycles
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= S_IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (accept) begin
						state_q <= S_LOW;
						cnt_q   <= prescale_i;
						bit_q   <= '0;
					end
				end
				S_LOW: begin
					if (tick) begin
						state_q <= S_HIGH;
						cnt_q   <= presc_q;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				S_HIGH: begin
					if (tick) begin
						cnt_q <= presc_q;
						if (last_bit) begin
							state_q <= S_LATCH;
						end else begin
							state_q <= S_LOW;
							bit_q   <= bit_q + 1'b1;
						end
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				S_LATCH: begin
					if (tick) begin
						state_q <= S_IDLE;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// word shifts left after each sclk high phase, msb goes out first
	always_ff @(posedge clk_i) begin
		if (accept) begin
			word_q  <= serial_req_i.data;
			mask_q  <= sel_mask;
			presc_q <= prescale_i;
		end else if ((state_q == S_HIGH) && tick && !last_bit) begin
			word_q <= word_q << 1;
		end
	end

	assign busy_o = (state_q != S_IDLE);
	assign sclk_o = (state_q == S_HIGH);
	assign sin_o  = ((state_q == S_LOW) || (state_q == S_HIGH)) ?
		(mask_q & {NUM_LABS{word_q[SERIAL_W-1]}}) : '0;
	assign pclk_o = (state_q == S_LATCH) ? mask_q : '0;

endmodule

/* hdl/wilkinson_ramp_seq.sv */
module wilkinson_ramp_seq (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     ramp_start_i,
	input  logic                     wilk_reset_i,
	input  lab4_chip_pkg::ramp_cfg_t ramp_cfg_i,
	output logic                     ramp_pending_o,
	output logic                     ramp_o,
	output logic                     wclk_o
);
	import lab4_chip_pkg::*;

	typedef enum logic [1:0] {
		R_IDLE,
		R_DELAY,
		R_COUNT
	} state_t;

	state_t     state_q;
	wilk_time_t dly_cnt_q;
	wilk_time_t edge_rem_q;
	wilk_time_t stop_q;
	logic       wclk_q;
	logic       start_ok;

	// starts while a ramp runs are dropped
	assign start_ok = ramp_start_i && (state_q == R_IDLE);

	always_ff @(posedge clk_i) begin
		if (start_ok) begin
			stop_q <= ramp_cfg_i.stop;
		end
	end

	////////////////////////////////////////
	// ramp and count clock
	////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= R_IDLE;
			dly_cnt_q  <= '0;
			edge_rem_q <= '0;
			wclk_q     <= 1'b0;
		end else if (wilk_reset_i) begin
			// abort
			state_q <= R_IDLE;
			wclk_q  <= 1'b0;
		end else begin
			case (state_q)
				R_IDLE: begin
					if (start_ok && (ramp_cfg_i.delay != '0)) begin
						state_q   <= R_DELAY;
						dly_cnt_q <= ramp_cfg_i.delay - 1'b1;
					end else if (start_ok && (ramp_cfg_i.stop != '0)) begin
						state_q    <= R_COUNT;
						wclk_q     <= 1'b1;
						edge_rem_q <= ramp_cfg_i.stop - 1'b1;
					end
				end
				R_DELAY: begin
					if (dly_cnt_q != '0) begin
						dly_cnt_q <= dly_cnt_q - 1'b1;
					end else if (stop_q != '0) begin
						state_q    <= R_COUNT;
						wclk_q     <= 1'b1;
						edge_rem_q <= stop_q - 1'b1;
					end else begin
						state_q <= R_IDLE;
					end
				end
				R_COUNT: begin
					// high then low, N periods, ends on a low cycle
					if (wclk_q) begin
						wclk_q <= 1'b0;
					end else if (edge_rem_q == '0) begin
						state_q <= R_IDLE;
					end else begin
						wclk_q     <= 1'b1;
						edge_rem_q <= edge_rem_q - 1'b1;
					end
				end
				default: state_q <= R_IDLE;
			endcase
		end
	end

	assign ramp_o         = (state_q != R_IDLE);
	assign ramp_pending_o = ramp_o;
	assign wclk_o         = wclk_q;

endmodule

/* hdl/lab4d_controller.sv */
module lab4d_controller (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  lab4_bus_pkg::bus_req_t  bus_req_i,
	output lab4_bus_pkg::bus_rsp_t  bus_rsp_o,
	output lab4_chip_pkg::lab_vec_t sin_o,
	output logic                    sclk_o,
	output lab4_chip_pkg::lab_vec_t pclk_o,
	output logic                    ramp_o,
	output logic                    wclk_o,
	output logic                    runmode_o,
	output logic                    regclr_o
);
	import lab4_chip_pkg::*;

	serial_req_t serial_req;
	logic        serial_busy;
	logic        ramp_start;
	logic        wilk_reset;
	ramp_cfg_t   ramp_cfg;
	logic        ramp_pending;
	prescale_t   prescale;

	////////////////////////////////////////
	// bus side
	////////////////////////////////////////

	lab4_reg_bank u_reg_bank (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.bus_req_i      (bus_req_i),
		.bus_rsp_o      (bus_rsp_o),
		.serial_req_o   (serial_req),
		.serial_busy_i  (serial_busy),
		.ramp_start_o   (ramp_start),
		.wilk_reset_o   (wilk_reset),
		.ramp_cfg_o     (ramp_cfg),
		.ramp_pending_i (ramp_pending),
		.prescale_o     (prescale),
		.runmode_o      (runmode_o),
		.regclr_o       (regclr_o)
	);

	////////////////////////////////////////
	// chip side engines
	////////////////////////////////////////

	lab4_serial_shifter u_shifter (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.serial_req_i (serial_req),
		.prescale_i   (prescale),
		.busy_o       (serial_busy),
		.sin_o        (sin_o),
		.sclk_o       (sclk_o),
		.pclk_o       (pclk_o)
	);

	wilkinson_ramp_seq u_ramp (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.ramp_start_i   (ramp_start),
		.wilk_reset_i   (wilk_reset),
		.ramp_cfg_i     (ramp_cfg),
		.ramp_pending_o (ramp_pending),
		.ramp_o         (ramp_o),
		.wclk_o         (wclk_o)
	);

endmodule

/* verif/lab4d_controller_asserts.sv */
module lab4d_controller_asserts (
	input logic                    clk_i,
	input logic                    rst_n_i,
	input lab4_bus_pkg::bus_req_t  bus_req_i,
	input lab4_bus_pkg::bus_rsp_t  bus_rsp_i,
	input logic                    sclk_i,
	input lab4_chip_pkg::lab_vec_t pclk_i,
	input logic                    ramp_i,
	input logic                    wclk_i
);

	logic req;

	assign req = bus_req_i.cyc && bus_req_i.stb;

	// shift clock and latch clock never overlap
	sclk_pclk_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(sclk_i && (|pclk_i)))
		else $error("sclk and pclk high in the same cycle");

	// count clock moves only inside a ramp
	wclk_in_ramp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$changed(wclk_i) |-> ($past(ramp_i) || ramp_i))
		else $error("wclk toggled while ramp was low");

	ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		req |=> bus_rsp_i.ack)
		else $error("no ack one cycle after a bus request");

	no_ack_without_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!req |=> !bus_rsp_i.ack)
		else $error("ack without a bus request in the cycle before");

endmodule

bind lab4d_controller lab4d_controller_asserts u_asserts (
	.clk_i     (clk_i),
	.rst_n_i   (rst_n_i),
	.bus_req_i (bus_req_i),
	.bus_rsp_i (bus_rsp_o),
	.sclk_i    (sclk_o),
	.pclk_i    (pclk_o),
	.ramp_i    (ramp_o),
	.wclk_i    (wclk_o)
);

/* verif/tb_lab4d_controller.sv */
module tb_lab4d_controller;
	import lab4_bus_pkg::*;
	import lab4_chip_pkg::*;

	localparam int NUM_RAND   = 40;
	localparam int NUM_SERIAL = 12;
	localparam int NUM_RAMP   = 10;
	localparam int NUM_ABORT  = 4;
	localparam int POLL_LIMIT = 400;
	// worst case per test is prescale 3, delay 20 and 40 count periods
	localparam int SERIAL_CYCLES  = 49 * 4 + 40;
	localparam int RAMP_CYCLES    = 20 + 2 * 40 + 30;
	localparam int ABORT_CYCLES   = 60;
	localparam int TIMEOUT_CYCLES = NUM_RAND * 12 + NUM_SERIAL * SERIAL_CYCLES
		+ NUM_RAMP * RAMP_CYCLES + NUM_ABORT * ABORT_CYCLES + 500;

	logic       clk;
	logic       rst_n;
	bus_req_t   bus_req;
	bus_rsp_t   bus_rsp;
	lab_vec_t   sin;
	logic       sclk;
	lab_vec_t   pclk;
	logic       ramp;
	logic       wclk;
	logic       runmode;
	logic       regclr;
	integer     seed;
	int         errors;
	int         checks;

	// register mirror
	logic       m_runmode;
	logic       m_regclr;
	prescale_t  m_presc;
	wilk_time_t m_delay;
	wilk_time_t m_stop;
	lab_word_t  m_uw_data;
	lab_sel_t   m_uw_sel;

	// pin activity seen by the monitor
	lab_word_t  cap [NUM_LABS];
	int         pclk_pulses [NUM_LABS];
	int         pclk_hi [NUM_LABS];
	int         sclk_rises;
	int         sclk_run;
	int         sclk_bad;
	int         exp_presc;
	int         ramp_cycles;
	int         wclk_rises;
	int         wclk_first;
	logic       sclk_prev;
	logic       wclk_prev;
	lab_vec_t   pclk_prev;

	logic [6:0] adr_pool [8] = '{7'h00, 7'h04, 7'h0C, 7'h10, 7'h18, 7'h08, 7'h14, 7'h1C};

	lab4d_controller DUT (
		.clk_i     (clk),
		.rst_n_i   (rst_n),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.sin_o     (sin),
		.sclk_o    (sclk),
		.pclk_o    (pclk),
		.ramp_o    (ramp),
		.wclk_o    (wclk),
		.runmode_o (runmode),
		.regclr_o  (regclr)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// pin monitor sampled mid-cycle
	////////////////////////////////////////

	always @(negedge clk) begin
		if (rst_n) begin
			if (sclk && !sclk_prev) begin
				sclk_rises++;
				for (int ch = 0; ch < NUM_LABS; ch++) begin
					cap[ch] = {cap[ch][SERIAL_W-2:0], sin[ch]};
				end
			end
			if (sclk) begin
				sclk_run++;
			end else if (sclk_prev) begin
				if (sclk_run != exp_presc + 1) begin
					sclk_bad++;
				end
				sclk_run = 0;
			end
			for (int ch = 0; ch < NUM_LABS; ch++) begin
				if (pclk[ch]) begin
					pclk_hi[ch]++;
				end
				if (pclk[ch] && !pclk_prev[ch]) begin
					pclk_pulses[ch]++;
				end
			end
			if (ramp) begin
				ramp_cycles++;
			end
			if (wclk && !wclk_prev) begin
				wclk_rises++;
				if (wclk_rises == 1) begin
					wclk_first = ramp_cycles;
				end
			end
		end
		sclk_prev = sclk;
		wclk_prev = wclk;
		pclk_prev = pclk;
	end

	task automatic clear_monitor();
		for (int ch = 0; ch < NUM_LABS; ch++) begin
			cap[ch]         = '0;
			pclk_pulses[ch] = 0;
			pclk_hi[ch]     = 0;
		end
		sclk_rises  = 0;
		sclk_run    = 0;
		sclk_bad    = 0;
		ramp_cycles = 0;
		wclk_rises  = 0;
		wclk_first  = 0;
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic rand_range(input int lo, input int hi, output int v);
		v = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	////////////////////////////////////////
	// bus access and register model
	////////////////////////////////////////

	// drives one request cycle from just after a rising edge
	task automatic bus_xfer(input logic we, input logic [6:0] adr, input logic [31:0] dat,
		output logic [31:0] rdat);
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we  = we;
		bus_req.adr = adr;
		bus_req.dat = dat;
		@(posedge clk);
		#2;
		bus_req = '0;
		check_eq("bus_ack", 32'd1, 32'(bus_rsp.ack));
		rdat = bus_rsp.dat;
	endtask

	function automatic logic [31:0] expected_read(input logic [6:0] adr, input logic pending,
		input logic busy);
		logic [31:0] v;
		v = '0;
		case (adr)
			7'h00: begin
				v[1]  = m_runmode;
				v[6]  = pending;
				v[16] = m_regclr;
			end
			7'h04: v[7:0] = m_presc;
			7'h0C: v[15:0] = m_delay;
			7'h10: v[15:0] = m_stop;
			7'h18: begin
				v[23:0]  = m_uw_data;
				v[26:24] = m_uw_sel;
				v[31]    = busy;
			end
			default: v = '0;
		endcase
		return v;
	endfunction

	task automatic write_reg(input logic [6:0] adr, input logic [31:0] dat);
		logic [31:0] rd;
		bus_xfer(1'b1, adr, dat, rd);
		case (adr)
			7'h00: begin
				m_runmode = dat[1];
				m_regclr  = dat[16];
			end
			7'h04: m_presc = dat[7:0];
			7'h0C: m_delay = dat[15:0];
			7'h10: m_stop = dat[15:0];
			7'h18: begin
				m_uw_data = dat[23:0];
				m_uw_sel  = dat[26:24];
			end
			default: ;
		endcase
		if (adr == ADR_CONTROL) begin
			check_eq("runmode_pin", 32'(m_runmode), 32'(runmode));
			check_eq("regclr_pin", 32'(m_regclr), 32'(regclr));
		end
	endtask

	task automatic read_check(input string name, input logic [6:0] adr, input logic [31:0] exp);
		logic [31:0] rd;
		bus_xfer(1'b0, adr, '0, rd);
		check_eq(name, exp, rd);
	endtask

	////////////////////////////////////////
	// test sequences
	////////////////////////////////////////

	task automatic serial_test(input lab_word_t data, input lab_sel_t sel, input prescale_t presc);
		lab_vec_t    mask;
		logic [31:0] rd;
		int          polls;
		mask = '0;
		for (int ch = 0; ch < NUM_LABS; ch++) begin
			mask[ch] = (sel == LAB_SEL_ALL) || (sel == ch);
		end
		write_reg(ADR_SHIFT_PRESCALE, 32'(presc));
		exp_presc = presc;
		clear_monitor();
		write_reg(ADR_USER_WRITE, {1'b1, 4'b0, sel, data});
		// second go lands while the first word shifts
		write_reg(ADR_USER_WRITE, {1'b1, 4'b0, sel, 24'($random(seed))});
		read_check("serial_busy", ADR_USER_WRITE, expected_read(ADR_USER_WRITE, 1'b0, 1'b1));
		rd = 32'h8000_0000;
		polls = 0;
		while (rd[UW_GO_BIT] && polls < POLL_LIMIT) begin
			bus_xfer(1'b0, ADR_USER_WRITE, '0, rd);
			polls++;
		end
		assert (!rd[UW_GO_BIT]) else begin
			errors++;
			$display("serial busy still set after %0d polls", POLL_LIMIT);
		end
		check_eq("sclk_edges", 32'd24, 32'(sclk_rises));
		check_eq("sclk_high_time_errors", 32'd0, 32'(sclk_bad));
		for (int ch = 0; ch < NUM_LABS; ch++) begin
			check_eq($sformatf("sin_word_lab%0d", ch), mask[ch] ? 32'(data) : 32'd0,
				32'(cap[ch]));
			check_eq($sformatf("pclk_pulses_lab%0d", ch), mask[ch] ? 32'd1 : 32'd0,
				32'(pclk_pulses[ch]));
			check_eq($sformatf("pclk_high_lab%0d", ch), mask[ch] ? 32'(presc + 1) : 32'd0,
				32'(pclk_hi[ch]));
		end
		read_check("serial_done", ADR_USER_WRITE, expected_read(ADR_USER_WRITE, 1'b0, 1'b0));
	endtask

	task automatic ramp_test(input wilk_time_t d, input wilk_time_t n);
		logic [31:0] ctl;
		logic [31:0] rd;
		int          polls;
		write_reg(ADR_RAMP_DELAY, 32'(d));
		write_reg(ADR_WILK_STOP, 32'(n));
		clear_monitor();
		ctl = $random(seed) & 32'h0001_0002;
		ctl[CTL_RAMP_BIT] = 1'b1;
		write_reg(ADR_CONTROL, ctl);
		idle_cycles(1);
		read_check("ramp_pending", ADR_CONTROL, expected_read(ADR_CONTROL, 1'b1, 1'b0));
		rd = 32'h40;
		polls = 0;
		while (rd[CTL_RAMP_BIT] && polls < POLL_LIMIT) begin
			bus_xfer(1'b0, ADR_CONTROL, '0, rd);
			polls++;
		end
		assert (!rd[CTL_RAMP_BIT]) else begin
			errors++;
			$display("ramp still pending after %0d polls", POLL_LIMIT);
		end
		check_eq("ramp_high_cycles", 32'(d + 2 * n), 32'(ramp_cycles));
		check_eq("wclk_rising_edges", 32'(n), 32'(wclk_rises));
		check_eq("wclk_first_cycle", 32'(d + 1), 32'(wclk_first));
		read_check("ramp_done", ADR_CONTROL, expected_read(ADR_CONTROL, 1'b0, 1'b0));
	endtask

	task automatic abort_test(input wilk_time_t d, input wilk_time_t n, input int wait_n);
		logic [31:0] ctl;
		write_reg(ADR_RAMP_DELAY, 32'(d));
		write_reg(ADR_WILK_STOP, 32'(n));
		ctl = $random(seed) & 32'h0001_0002;
		ctl[CTL_RAMP_BIT] = 1'b1;
		write_reg(ADR_CONTROL, ctl);
		idle_cycles(wait_n);
		check_eq("abort_ramp_active", 32'd1, 32'(ramp));
		ctl = $random(seed) & 32'h0001_0002;
		ctl[CTL_WILK_RESET_BIT] = 1'b1;
		write_reg(ADR_CONTROL, ctl);
		// strobe cycle, then the cycle where ramp must be gone
		@(negedge clk);
		@(negedge clk);
		check_eq("abort_ramp_low", 32'd0, 32'(ramp));
		check_eq("abort_wclk_low", 32'd0, 32'(wclk));
		@(posedge clk);
		#2;
		read_check("abort_pending", ADR_CONTROL, expected_read(ADR_CONTROL, 1'b0, 1'b0));
	endtask

	initial begin
		int         idx;
		int         v;
		int         d;
		int         n;
		logic [6:0] adr;
		logic [31:0] dat;
		lab_sel_t   sel;

		clk       = 1'b0;
		rst_n     = 1'b0;
		bus_req   = '0;
		seed      = 32'hbc5b;
		errors    = 0;
		checks    = 0;
		exp_presc = 0;
		m_runmode = 1'b0;
		m_regclr  = 1'b0;
		m_presc   = 8'd0;
		m_delay   = 16'd0;
		m_stop    = 16'd1024;
		m_uw_data = '0;
		m_uw_sel  = '0;
		sclk_prev = 1'b0;
		wclk_prev = 1'b0;
		pclk_prev = '0;
		clear_monitor();

		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		idle_cycles(1);

		// defaults after reset plus one unmapped address
		for (int i = 0; i < 6; i++) begin
			read_check("reset_default", adr_pool[i], expected_read(adr_pool[i], 1'b0, 1'b0));
		end

		// random register traffic with starts and aborts masked off
		repeat (NUM_RAND) begin
			rand_range(0, 8, idx);
			adr = (idx == 8) ? 7'($random(seed)) : adr_pool[idx];
			dat = $random(seed);
			if (adr == ADR_CONTROL) begin
				dat[CTL_RAMP_BIT]       = 1'b0;
				dat[CTL_WILK_RESET_BIT] = 1'b0;
			end
			if (adr == ADR_USER_WRITE) begin
				dat[UW_GO_BIT] = 1'b0;
			end
			rand_range(0, 3, v);
			if (v != 0) begin
				write_reg(adr, dat);
			end
			read_check("reg_readback", adr, expected_read(adr, 1'b0, 1'b0));
		end

		for (int i = 0; i < NUM_SERIAL; i++) begin
			rand_range(0, 4, v);
			sel = (v == 4 || i == 0) ? LAB_SEL_ALL : lab_sel_t'(v);
			rand_range(0, 3, v);
			serial_test(24'($random(seed)), sel, prescale_t'(v));
		end

		for (int i = 0; i < NUM_RAMP; i++) begin
			rand_range(0, 20, d);
			rand_range(1, 40, n);
			ramp_test(wilk_time_t'(d), wilk_time_t'(n));
		end

		for (int i = 0; i < NUM_ABORT; i++) begin
			rand_range(0, 10, d);
			rand_range(20, 40, n);
			rand_range(0, 5, v);
			// checked cycle falls on a count clock high phase
			abort_test(wilk_time_t'(d), wilk_time_t'(n), d + 2 * v + 1);
		end

		idle_cycles(2);
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* list.f */
hdl/lab4_bus_pkg.sv
hdl/lab4_chip_pkg.sv
hdl/lab4_reg_bank.sv
hdl/lab4_serial_shifter.sv
hdl/wilkinson_ramp_seq.sv
hdl/lab4d_controller.sv
verif/lab4d_controller_asserts.sv
verif/tb_lab4d_controller.sv
